//--- ahb_decoder.sv
`include "soc_params.svh"

module ahb_decoder (
    input  logic              clk,
    input  logic              rst_n,
    input  soc_pkg::ahb_req_t bus_req,
    input  soc_pkg::ahb_rsp_t clint_rsp,
    input  soc_pkg::ahb_rsp_t dtube_rsp,
    output logic              hsel_clint,
    output logic              hsel_dtube,
    output soc_pkg::ahb_rsp_t bus_rsp
);

    logic in_clint;
    logic in_dtube;
    logic addr_phase;
    logic dsel_clint;   // data-phase owner
    logic dsel_dtube;
    logic err_1;        // first error cycle, hready low
    logic err_2;        // second error cycle, hready high

    // region match on the address-phase address
    assign in_clint = (bus_req.haddr >= `CLINT_BASE) &&
                      (bus_req.haddr < (`CLINT_BASE + `CLINT_SIZE));
    assign in_dtube = (bus_req.haddr >= `DTUBE_BASE) &&
                      (bus_req.haddr < (`DTUBE_BASE + `DTUBE_SIZE));

    assign addr_phase = ((bus_req.htrans == soc_pkg::NONSEQ) ||
                         (bus_req.htrans == soc_pkg::SEQ)) && bus_rsp.hready;

    // selects only pulse on a real address phase
    assign hsel_clint = addr_phase && in_clint;
    assign hsel_dtube = addr_phase && in_dtube;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dsel_clint <= 1'b0;
            dsel_dtube <= 1'b0;
            err_1      <= 1'b0;
            err_2      <= 1'b0;
        end else begin
            err_2 <= err_1;
            if (bus_rsp.hready) begin
                dsel_clint <= hsel_clint;
                dsel_dtube <= hsel_dtube;
                err_1      <= addr_phase && !in_clint && !in_dtube; // default slave
            end else begin
                err_1 <= 1'b0;
            end
        end
    end

    // data-phase response mux
    always_comb begin
        bus_rsp.hrdata = '0;
        bus_rsp.hready = 1'b1;
        bus_rsp.hresp  = soc_pkg::OKAY;
        if (err_1) begin
            bus_rsp.hready = 1'b0;
            bus_rsp.hresp  = soc_pkg::ERROR;
        end else if (err_2) begin
            bus_rsp.hresp = soc_pkg::ERROR;
        end else if (dsel_clint) begin
            bus_rsp = clint_rsp;
        end else if (dsel_dtube) begin
            bus_rsp = dtube_rsp;
        end
    end

endmodule

//--- all.f
+incdir+.
soc_pkg.sv
seg_digit.sv
ahb_decoder.sv
clint.sv
dtube.sv
soc_periph_top.sv
soc_periph_asserts.sv
tb_soc_periph.sv

//--- clint.sv
`include "soc_params.svh"

module clint (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              rtc_toggle,   // async
    input  logic              hsel,
    input  soc_pkg::ahb_req_t bus_req,
    output soc_pkg::ahb_rsp_t rsp,
    output logic              irq_timer,
    output logic              irq_software
);

    logic [2:0]                 rtc_sync;   // two sync stages plus history
    logic                       rtc_edge;
    logic                       active_q;
    logic                       write_q;
    logic [15:0]                addr_q;
    logic                       wr_en;
    logic                       msip;
    logic [2*`WORD_WIDTH-1:0]   mtime;
    logic [2*`WORD_WIDTH-1:0]   mtimecmp;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rtc_sync <= 3'b000;
        end else begin
            rtc_sync <= {rtc_sync[1:0], rtc_toggle};
        end
    end

    // both edges of the toggle count
    assign rtc_edge = rtc_sync[2] ^ rtc_sync[1];

    // address phase capture
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active_q <= 1'b0;
        end else begin
            active_q <= hsel;
        end
    end

    always_ff @(posedge clk) begin
        if (hsel) begin
            addr_q  <= bus_req.haddr[15:0];
            write_q <= bus_req.hwrite;
        end
    end

    assign wr_en = active_q && write_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            msip     <= 1'b0;
            mtimecmp <= '1;     // keeps irq_timer low out of reset
            mtime    <= '0;
        end else begin
            if (wr_en && addr_q == `MSIP_OFF)
                msip <= bus_req.hwdata[0];
            if (wr_en && addr_q == `MTIMECMP_LO_OFF)
                mtimecmp[`WORD_WIDTH-1:0] <= bus_req.hwdata;
            if (wr_en && addr_q == `MTIMECMP_HI_OFF)
                mtimecmp[2*`WORD_WIDTH-1:`WORD_WIDTH] <= bus_req.hwdata;

            // a bus write wins over the count
            if (wr_en && addr_q == `MTIME_LO_OFF)
                mtime[`WORD_WIDTH-1:0] <= bus_req.hwdata;
            else if (wr_en && addr_q == `MTIME_HI_OFF)
                mtime[2*`WORD_WIDTH-1:`WORD_WIDTH] <= bus_req.hwdata;
            else if (rtc_edge)
                mtime <= mtime + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            irq_timer    <= 1'b0;
            irq_software <= 1'b0;
        end else begin
            irq_timer    <= (mtime >= mtimecmp);
            irq_software <= msip;
        end
    end

    // read data for the data phase
    always_comb begin
        rsp.hrdata = '0;
        rsp.hready = 1'b1;  // zero wait states
        rsp.hresp  = soc_pkg::OKAY;
        case (addr_q)
            `MSIP_OFF:        rsp.hrdata = {{(`WORD_WIDTH-1){1'b0}}, msip};
            `MTIMECMP_LO_OFF: rsp.hrdata = mtimecmp[`WORD_WIDTH-1:0];
            `MTIMECMP_HI_OFF: rsp.hrdata = mtimecmp[2*`WORD_WIDTH-1:`WORD_WIDTH];
            `MTIME_LO_OFF:    rsp.hrdata = mtime[`WORD_WIDTH-1:0];
            `MTIME_HI_OFF:    rsp.hrdata = mtime[2*`WORD_WIDTH-1:`WORD_WIDTH];
            default:          rsp.hrdata = '0;
        endcase
    end

endmodule

//--- dtube.sv
`include "soc_params.svh"

module dtube (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         hsel,
    input  soc_pkg::ahb_req_t            bus_req,
    output soc_pkg::ahb_rsp_t            rsp,
    output logic [`NUM_DIGITS-1:0][7:0]  hex
);

    logic                           active_q;
    logic                           write_q;
    logic [11:0]                    addr_q;
    logic                           wr_en;
    logic [4*`NUM_DIGITS-1:0]       digits;
    logic [`NUM_DIGITS-1:0]         blank_mask;
    logic [`NUM_DIGITS-1:0]         dot_mask;
    logic [`NUM_DIGITS-1:0][7:0]    seg_next;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active_q <= 1'b0;
        end else begin
            active_q <= hsel;
        end
    end

    always_ff @(posedge clk) begin
        if (hsel) begin
            addr_q  <= bus_req.haddr[11:0];
            write_q <= bus_req.hwrite;
        end
    end

    assign wr_en = active_q && write_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            digits     <= '0;
            blank_mask <= '1;   // display dark until software writes ctrl
            dot_mask   <= '0;
        end else if (wr_en) begin
            if (addr_q == `DIGITS_OFF)
                digits <= bus_req.hwdata[4*`NUM_DIGITS-1:0];
            if (addr_q == `CTRL_OFF) begin
                blank_mask <= bus_req.hwdata[`NUM_DIGITS-1:0];
                dot_mask   <= bus_req.hwdata[8 +: `NUM_DIGITS];
            end
        end
    end

    always_comb begin
        rsp.hrdata = '0;
        rsp.hready = 1'b1;
        rsp.hresp  = soc_pkg::OKAY;
        if (addr_q == `DIGITS_OFF)
            rsp.hrdata[4*`NUM_DIGITS-1:0] = digits;
        else if (addr_q == `CTRL_OFF) begin
            rsp.hrdata[`NUM_DIGITS-1:0]  = blank_mask;
            rsp.hrdata[8 +: `NUM_DIGITS] = dot_mask;
        end
    end

    for (genvar i = 0; i < `NUM_DIGITS; i++) begin : g_digit
        seg_digit u_seg_digit (
            .nibble (digits[4*i +: 4]),
            .blank  (blank_mask[i]),
            .dot    (dot_mask[i]),
            .seg    (seg_next[i])
        );
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hex <= {`NUM_DIGITS{8'hff}};
        end else begin
            hex <= seg_next;    // one cycle behind the registers
        end
    end

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
    --top-module tb_soc_periph -f all.f

# the simulator may exit early on an assertion, the grep decides
out=$(./obj_dir/Vtb_soc_periph) || true
echo "$out"
echo "$out" | grep -q "All tests passed"

//--- seg_digit.sv
module seg_digit (
    input  logic [3:0] nibble,
    input  logic       blank,
    input  logic       dot,
    output logic [7:0] seg
);

    logic [6:0] glyph;  // gfedcba, active low

    always_comb begin
        case (nibble)
            4'h0: glyph = 7'h40;
            4'h1: glyph = 7'h79;
            4'h2: glyph = 7'h24;
            4'h3: glyph = 7'h30;
            4'h4: glyph = 7'h19;
            4'h5: glyph = 7'h12;
            4'h6: glyph = 7'h02;
            4'h7: glyph = 7'h78;
            4'h8: glyph = 7'h00;
            4'h9: glyph = 7'h10;
            4'ha: glyph = 7'h08;
            4'hb: glyph = 7'h03;    // lower case b
            4'hc: glyph = 7'h46;
            4'hd: glyph = 7'h21;    // lower case d
            4'he: glyph = 7'h06;
            default: glyph = 7'h0e;
        endcase
    end

    // blanking also kills the dot
    assign seg = blank ? 8'hff : {~dot, glyph};

endmodule

//--- soc_params.svh
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

`define WORD_WIDTH          32

// address map
`define CLINT_BASE          32'h0200_0000
`define CLINT_SIZE          32'h0001_0000   // 64 KB
`define DTUBE_BASE          32'h1000_2000
`define DTUBE_SIZE          32'h0000_1000   // 4 KB

// clint registers, offset within region
`define MSIP_OFF            16'h0000
`define MTIMECMP_LO_OFF     16'h4000
`define MTIMECMP_HI_OFF     16'h4004
`define MTIME_LO_OFF        16'hBFF8
`define MTIME_HI_OFF        16'hBFFC

// dtube registers
`define DIGITS_OFF          12'h000     // six nibbles in 23..0
`define CTRL_OFF            12'h004     // blank 5..0, dot 13..8

`define NUM_DIGITS          6

`endif

//--- soc_periph_asserts.sv
module soc_periph_asserts (
    input logic              clk,
    input logic              rst_n,
    input soc_pkg::ahb_rsp_t bus_rsp,
    input logic              hsel_clint,
    input logic              hsel_dtube
);
    timeunit 1ns;
    timeprecision 100ps;

    // error response is low then high, never longer
    a_err_second: assert property (@(posedge clk) disable iff (!rst_n)
        (!bus_rsp.hready && bus_rsp.hresp == soc_pkg::ERROR) |=>
        (bus_rsp.hready && bus_rsp.hresp == soc_pkg::ERROR))
        else $error("error response did not end with hready high");

    a_err_first: assert property (@(posedge clk) disable iff (!rst_n)
        (bus_rsp.hready && bus_rsp.hresp == soc_pkg::ERROR) |->
        $past(!bus_rsp.hready && bus_rsp.hresp == soc_pkg::ERROR))
        else $error("error response started without the hready low cycle");

    a_stall_short: assert property (@(posedge clk) disable iff (!rst_n)
        !bus_rsp.hready |=> bus_rsp.hready)
        else $error("hready held low for more than one cycle");

    a_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown({bus_rsp, hsel_clint, hsel_dtube}))
        else $error("unknown value on decoder outputs");

    a_reset_rsp: assert property (@(posedge clk)
        !rst_n |=> (bus_rsp.hready && bus_rsp.hresp == soc_pkg::OKAY))
        else $error("response not idle after reset");

endmodule

bind ahb_decoder soc_periph_asserts u_asserts (
    .clk        (clk),
    .rst_n      (rst_n),
    .bus_rsp    (bus_rsp),
    .hsel_clint (hsel_clint),
    .hsel_dtube (hsel_dtube)
);

//--- soc_periph_top.sv
module soc_periph_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              rtc_toggle,
    input  soc_pkg::ahb_req_t bus_req,
    output soc_pkg::ahb_rsp_t bus_rsp,
    output logic              irq_timer,
    output logic              irq_software,
    output logic [7:0]        dtube_hex0,
    output logic [7:0]        dtube_hex1,
    output logic [7:0]        dtube_hex2,
    output logic [7:0]        dtube_hex3,
    output logic [7:0]        dtube_hex4,
    output logic [7:0]        dtube_hex5
);

    logic              hsel_clint;
    logic              hsel_dtube;
    soc_pkg::ahb_rsp_t clint_rsp;
    soc_pkg::ahb_rsp_t dtube_rsp;

    ahb_decoder u_ahb_decoder (
        .clk        (clk),
        .rst_n      (rst_n),
        .bus_req    (bus_req),
        .clint_rsp  (clint_rsp),
        .dtube_rsp  (dtube_rsp),
        .hsel_clint (hsel_clint),
        .hsel_dtube (hsel_dtube),
        .bus_rsp    (bus_rsp)
    );

    clint u_clint (
        .clk          (clk),
        .rst_n        (rst_n),
        .rtc_toggle   (rtc_toggle),
        .hsel         (hsel_clint),
        .bus_req      (bus_req),
        .rsp          (clint_rsp),
        .irq_timer    (irq_timer),
        .irq_software (irq_software)
    );

    dtube u_dtube (
        .clk     (clk),
        .rst_n   (rst_n),
        .hsel    (hsel_dtube),
        .bus_req (bus_req),
        .rsp     (dtube_rsp),
        .hex     ({dtube_hex5, dtube_hex4, dtube_hex3,
                   dtube_hex2, dtube_hex1, dtube_hex0})  // digit 0 in the low byte
    );

endmodule

//--- soc_pkg.sv
`include "soc_params.svh"

package soc_pkg;

    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_e;

    // only two of the four ahb codes are ever driven
    typedef enum logic [1:0] {
        OKAY  = 2'b00,
        ERROR = 2'b01
    } hresp_e;

    typedef struct packed {
        logic [`WORD_WIDTH-1:0] haddr;
        logic                   hwrite;
        htrans_e                htrans;
        logic [`WORD_WIDTH-1:0] hwdata;     // data phase
    } ahb_req_t;

    typedef struct packed {
        logic [`WORD_WIDTH-1:0] hrdata;
        logic                   hready;
        hresp_e                 hresp;
    } ahb_rsp_t;

endpackage

//--- tb_soc_periph.sv
`include "soc_params.svh"

module tb_soc_periph;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_PAIRS = 20;
    localparam int N_ERR = 12;
    localparam int N_MIX = 200;
    localparam int TOTAL_XFERS = 7 + 4 * N_PAIRS + 8 + 7 + 2 * N_ERR + N_MIX;
    localparam int MARGIN = 1000;   // reset, idle gaps, rtc toggles

    localparam logic [31:0] A_MSIP    = `CLINT_BASE + `MSIP_OFF;
    localparam logic [31:0] A_CMP_LO  = `CLINT_BASE + `MTIMECMP_LO_OFF;
    localparam logic [31:0] A_CMP_HI  = `CLINT_BASE + `MTIMECMP_HI_OFF;
    localparam logic [31:0] A_TIME_LO = `CLINT_BASE + `MTIME_LO_OFF;
    localparam logic [31:0] A_TIME_HI = `CLINT_BASE + `MTIME_HI_OFF;
    localparam logic [31:0] A_DIGITS  = `DTUBE_BASE + `DIGITS_OFF;
    localparam logic [31:0] A_CTRL    = `DTUBE_BASE + `CTRL_OFF;
    localparam logic [31:0] REGS [7] = '{A_MSIP, A_CMP_LO, A_CMP_HI, A_TIME_LO,
                                         A_TIME_HI, A_DIGITS, A_CTRL};

    // active low segments in gfedcba order
    localparam logic [6:0] SEG_TABLE [16] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12,
                                              7'h02, 7'h78, 7'h00, 7'h10, 7'h08, 7'h03,
                                              7'h46, 7'h21, 7'h06, 7'h0e};

    logic clk = 1'b0;
    logic rst_n;
    logic rtc_toggle;
    soc_pkg::ahb_req_t bus_req;
    soc_pkg::ahb_rsp_t bus_rsp;
    logic irq_timer;
    logic irq_software;
    logic [`NUM_DIGITS-1:0][7:0] hex;

    integer seed = 32'h0caf_1599;
    int checks = 0;
    int errors = 0;
    int tests = 0;
    int test_errs = 0;

    // reference model state
    logic        m_msip = 1'b0;
    logic [63:0] m_mtimecmp = '1;
    logic [63:0] m_mtime = '0;
    logic [23:0] m_digits = '0;
    logic [5:0]  m_blank = '1;
    logic [5:0]  m_dot = '0;

    logic [31:0] q_addr[$];
    logic        q_write[$];
    logic [31:0] q_wdata[$];

    soc_periph_top dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .rtc_toggle   (rtc_toggle),
        .bus_req      (bus_req),
        .bus_rsp      (bus_rsp),
        .irq_timer    (irq_timer),
        .irq_software (irq_software),
        .dtube_hex0   (hex[0]),
        .dtube_hex1   (hex[1]),
        .dtube_hex2   (hex[2]),
        .dtube_hex3   (hex[3]),
        .dtube_hex4   (hex[4]),
        .dtube_hex5   (hex[5])
    );

    always #2 clk = ~clk;

    function automatic int rand_below(input int n);
        return {$random(seed)} % n;
    endfunction

    function automatic bit is_mapped(input logic [31:0] a);
        return (a >= `CLINT_BASE && a < `CLINT_BASE + `CLINT_SIZE) ||
               (a >= `DTUBE_BASE && a < `DTUBE_BASE + `DTUBE_SIZE);
    endfunction

    function automatic logic [31:0] unmapped_addr();
        logic [31:0] a;
        a = {$random(seed)} & 32'hffff_fffc;
        while (is_mapped(a))
            a = {$random(seed)} & 32'hffff_fffc;
        return a;
    endfunction

    function automatic logic [31:0] model_read(input logic [31:0] a);
        case (a)
            A_MSIP:    return {31'd0, m_msip};
            A_CMP_LO:  return m_mtimecmp[31:0];
            A_CMP_HI:  return m_mtimecmp[63:32];
            A_TIME_LO: return m_mtime[31:0];
            A_TIME_HI: return m_mtime[63:32];
            A_DIGITS:  return {8'd0, m_digits};
            A_CTRL:    return {18'd0, m_dot, 2'd0, m_blank};
            default:   return 32'd0;
        endcase
    endfunction

    task automatic model_write(input logic [31:0] a, input logic [31:0] d);
        case (a)
            A_MSIP:    m_msip = d[0];   // upper bits dropped
            A_CMP_LO:  m_mtimecmp[31:0] = d;
            A_CMP_HI:  m_mtimecmp[63:32] = d;
            A_TIME_LO: m_mtime[31:0] = d;
            A_TIME_HI: m_mtime[63:32] = d;
            A_DIGITS:  m_digits = d[23:0];
            A_CTRL: begin
                m_blank = d[5:0];
                m_dot   = d[13:8];
            end
            default: ;
        endcase
    endtask

    function automatic logic [7:0] exp_seg(input int i);
        if (m_blank[i])
            return 8'hff;
        return {~m_dot[i], SEG_TABLE[m_digits[4*i +: 4]]};
    endfunction

    task automatic check_rsp(input soc_pkg::ahb_rsp_t got, input soc_pkg::ahb_rsp_t exp,
                             input logic [31:0] a);
        checks++;
        if (got.hready !== exp.hready || got.hresp !== exp.hresp) begin
            errors++;
            $display("error at %0d ns: response to %h is hready %b hresp %0d, expected %b %0d",
                     $time, a, got.hready, got.hresp, exp.hready, exp.hresp);
        end
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp,
                              input logic [31:0] a);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0d ns: read of %h returned %h, expected %h", $time, a, got, exp);
        end
    endtask

    task automatic check_hex(input logic [7:0] got, input logic [7:0] exp, input int digit);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0d ns: hex%0d is %h, expected %h", $time, digit, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string name);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0d ns: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_all_hex();
        for (int i = 0; i < `NUM_DIGITS; i++)
            check_hex(hex[i], exp_seg(i), i);
    endtask

    task automatic push_xfer(input logic [31:0] a, input logic w, input logic [31:0] d);
        q_addr.push_back(a);
        q_write.push_back(w);
        q_wdata.push_back(d);
    endtask

    // drains the queue as a pipelined burst, holding everything while hready is low
    task automatic run_queue();
        int n;
        int issued;
        int done;
        int ap;
        int dp;
        int dp_cycles;
        bit rdy_seen;
        bit mapped;
        soc_pkg::ahb_rsp_t exp_rsp;
        n = q_addr.size();
        issued = 0;
        done = 0;
        ap = -1;
        dp = -1;
        dp_cycles = 0;
        rdy_seen = 1'b1;
        while (done < n) begin
            @(posedge clk);
            if (rdy_seen) begin
                dp = ap;
                dp_cycles = 0;
                ap = (issued < n) ? issued : -1;
                if (ap >= 0) begin
                    issued++;
                    bus_req.haddr  <= q_addr[ap];
                    bus_req.hwrite <= q_write[ap];
                    bus_req.htrans <= soc_pkg::NONSEQ;
                end else begin
                    bus_req.htrans <= soc_pkg::IDLE;
                end
                bus_req.hwdata <= (dp >= 0 && q_write[dp]) ? q_wdata[dp] : {$random(seed)};
            end
            @(negedge clk);
            rdy_seen = bus_rsp.hready;
            if (dp >= 0) begin
                mapped = is_mapped(q_addr[dp]);
                exp_rsp = '0;
                exp_rsp.hready = mapped || dp_cycles > 0;  // an error answers low then high
                exp_rsp.hresp = mapped ? soc_pkg::OKAY : soc_pkg::ERROR;
                check_rsp(bus_rsp, exp_rsp, q_addr[dp]);
                dp_cycles++;
                if (bus_rsp.hready) begin
                    done++;
                    if (mapped && q_write[dp])
                        model_write(q_addr[dp], q_wdata[dp]);
                    else if (mapped)
                        check_word(bus_rsp.hrdata, model_read(q_addr[dp]), q_addr[dp]);
                end
            end
        end
        q_addr.delete();
        q_write.delete();
        q_wdata.delete();
    endtask

    task automatic toggle_rtc(input int count);
        repeat (count) begin
            repeat (4 + rand_below(8)) @(posedge clk);
            rtc_toggle <= ~rtc_toggle;
            m_mtime++;
        end
        repeat (6) @(posedge clk);  // sync and count latency
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == test_errs)
            $display("test %0d %s: ok", tests, name);
        else
            $display("test %0d %s: %0d errors", tests, name, errors - test_errs);
        test_errs = errors;
    endtask

    initial begin
        int n;
        rst_n = 1'b0;
        rtc_toggle = 1'b0;
        bus_req = '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        @(negedge clk);
        check_all_hex();
        check_bit(irq_timer, 1'b0, "irq_timer");
        check_bit(irq_software, 1'b0, "irq_software");
        foreach (REGS[i])
            push_xfer(REGS[i], 1'b0, 32'd0);
        run_queue();
        end_test("reset values");

        repeat (N_PAIRS) begin
            push_xfer(A_DIGITS, 1'b1, {$random(seed)});
            push_xfer(A_CTRL, 1'b1, {$random(seed)});
            push_xfer(A_DIGITS, 1'b0, 32'd0);
            push_xfer(A_CTRL, 1'b0, 32'd0);
            run_queue();
            repeat (2) @(negedge clk);
            check_all_hex();
        end
        end_test("display registers");

        for (int i = 0; i < 4; i++) begin
            push_xfer(A_MSIP, 1'b1, (i == 0) ? 32'd1 : (i == 1) ? 32'hffff_fffe :
                                    (i == 2) ? 32'hffff_ffff : 32'd0);
            push_xfer(A_MSIP, 1'b0, 32'd0);
            run_queue();
            repeat (3) @(negedge clk);
            check_bit(irq_software, m_msip, "irq_software");
        end
        end_test("software interrupt");

        n = 3 + rand_below(14);
        toggle_rtc(n);
        push_xfer(A_TIME_LO, 1'b0, 32'd0);
        push_xfer(A_TIME_HI, 1'b0, 32'd0);
        run_queue();
        push_xfer(A_CMP_LO, 1'b1, m_mtime[31:0] + 32'd2);
        push_xfer(A_CMP_HI, 1'b1, m_mtime[63:32]);
        run_queue();
        repeat (3) @(negedge clk);
        check_bit(irq_timer, 1'b0, "irq_timer");
        while (m_mtime < m_mtimecmp) begin
            toggle_rtc(1);
            @(negedge clk);
            check_bit(irq_timer, m_mtime >= m_mtimecmp, "irq_timer");
        end
        push_xfer(A_CMP_LO, 1'b1, m_mtime[31:0] + 32'd100);
        run_queue();
        repeat (3) @(negedge clk);
        check_bit(irq_timer, 1'b0, "irq_timer");
        end_test("timer interrupt");

        repeat (N_ERR) begin
            push_xfer(unmapped_addr(), rand_below(2) != 0, {$random(seed)});
            push_xfer(REGS[rand_below(7)], rand_below(2) != 0, {$random(seed)});
        end
        run_queue();
        end_test("unmapped addresses");

        repeat (N_MIX)
            push_xfer(REGS[rand_below(7)], rand_below(2) != 0, {$random(seed)});
        run_queue();
        repeat (2) @(negedge clk);
        check_all_hex();
        end_test("pipelined mix");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

    initial begin
        repeat (TOTAL_XFERS * 10 + MARGIN) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles",
                 TOTAL_XFERS * 10 + MARGIN);
        $display("Some tests failed");
        $finish;
    end

endmodule
